// File: list.f
+incdir+include
logic/s2mm_pkg.sv
logic/sync_fifo.sv
logic/rx_frame_admit.sv
logic/rx_beat_mover.sv
logic/rx_status_writer.sv
logic/s2mm_rx_top.sv
verif/s2mm_rx_properties.sv
verif/tb_s2mm_rx.sv

// File: verif/tb_s2mm_rx.sv
// ############################################################
// testbench for the receive tail
// random frames are driven in and both output fifos are
// drained and compared with a reference model
// ############################################################
`timescale 1ns/1ps
`default_nettype none
`include "s2mm_settings.svh"

module tb_s2mm_rx
   import s2mm_pkg::*;
;
   localparam int wait_limit = 4000;
   // a wrongly admitted frame stays busy longer than this
   localparam int hold_window = 4;

   logic         s2mm_clk;
   logic         s2mm_resetn;
   data_beat_t   in_beat;
   logic         in_beat_wren;
   info_word_t   in_info;
   logic         in_info_wren;
   logic         good_rden;
   data_beat_t   good_rdata;
   logic         good_empty;
   logic         ctrl_rden;
   status_word_t ctrl_rdata;
   logic         ctrl_empty;
   logic         dbg_busy;

   // expected output streams
   data_beat_t   exp_beats[$];
   status_word_t exp_status[$];
   data_beat_t   frame_buf[`S2MM_FRAME_MAX_BEATS];
   int           errors, checks, tests, test_err_base;
   bit           stalled;
   bit           drain_en;

   s2mm_rx_top dut (.s2mm_clk, .s2mm_resetn, .in_beat, .in_beat_wren, .in_info,
      .in_info_wren, .good_rden, .good_rdata, .good_empty, .ctrl_rden, .ctrl_rdata,
      .ctrl_empty, .dbg_busy);

   initial s2mm_clk = 1'b0;
   always #20 s2mm_clk = ~s2mm_clk;

   // zero bytes unless keep is a run of ones from bit 0
   function automatic int unsigned keep_to_bytes(input logic [7:0] keep);
      int unsigned n;
      int i;
      n = 0;
      if ((keep & (keep + 8'd1)) == 8'd0)
      begin
         for (i = 0; i < 8; i++)
            n += keep[i];
      end
      return n;
   endfunction

   // reference model queues the good beats and status words of one frame
   function automatic void expect_frame(input int nbeats, input info_word_t info);
      int unsigned total;
      int i;
      status_word_t w;
      total = 0;
      if (!info.bad)
      begin
         for (i = 0; i < nbeats; i++)
         begin
            exp_beats.push_back(frame_buf[i]);
            total += keep_to_bytes(frame_buf[i].keep);
         end
         for (i = 0; i < `S2MM_STATUS_WORDS; i++)
         begin
            w = '0;
            w.strb = 4'hf;
            if (i == 0)
               w.payload = 32'h5000_0000;
            else if (i == 3)
               w.payload = info.csum_ok ? 32'h0000_0040 : 32'h0000_0080;
            else if (i == `S2MM_STATUS_WORDS - 1)
            begin
               w.last = 1'b1;
               w.payload = {16'h0000, 16'(total)};
            end
            exp_status.push_back(w);
         end
      end
   endfunction

   task automatic push_beat(input data_beat_t b);
      int waited;
      waited = 0;
      if (!stalled)
      begin
         while (dut.data_full && waited < wait_limit)
         begin
            in_beat_wren = 1'b0;
            @(negedge s2mm_clk);
            waited++;
         end
         if (dut.data_full)
         begin
            $display("timeout: data fifo never had room for the next beat");
            errors++;
            stalled = 1'b1;
         end
         else
         begin
            in_beat = b;
            in_beat_wren = 1'b1;
            @(negedge s2mm_clk);
         end
      end
      in_beat_wren = 1'b0;
   endtask

   task automatic push_info(input info_word_t info);
      int waited;
      waited = 0;
      if (!stalled)
      begin
         while (dut.info_full && waited < wait_limit)
         begin
            @(negedge s2mm_clk);
            waited++;
         end
         if (dut.info_full)
         begin
            $display("timeout: info fifo never had room for a status byte");
            errors++;
            stalled = 1'b1;
         end
         else
         begin
            in_info = info;
            in_info_wren = 1'b1;
            @(negedge s2mm_clk);
         end
      end
      in_info_wren = 1'b0;
   endtask

   // bad_sel picks good (0), bad (1) or random (2)
   // keep_sel picks a contiguous (0), any (1) or broken (2) last keep
   task automatic send_frame(input int bad_sel, input int keep_sel);
      int nbeats;
      int i;
      info_word_t info;
      nbeats = 1 + int'($urandom % `S2MM_FRAME_MAX_BEATS);
      for (i = 0; i < nbeats; i++)
      begin
         frame_buf[i].data = {$urandom, $urandom};
         frame_buf[i].keep = 8'hff;
         frame_buf[i].last = (i == nbeats - 1);
      end
      case (keep_sel)
         0: frame_buf[nbeats-1].keep = 8'((9'h1 << ($urandom % 9)) - 9'h1);
         1: frame_buf[nbeats-1].keep = 8'($urandom);
         default: frame_buf[nbeats-1].keep = (8'($urandom) & 8'hfe) | 8'h80;
      endcase
      info = '0;
      info.bad = (bad_sel == 2) ? 1'($urandom) : (bad_sel == 1);
      info.csum_ok = 1'($urandom);
      expect_frame(nbeats, info);
      for (i = 0; i < nbeats; i++)
         push_beat(frame_buf[i]);
      push_info(info);
   endtask

   function automatic bit all_done();
      return (exp_beats.size() == 0) && (exp_status.size() == 0) && !dbg_busy &&
         dut.info_empty;
   endfunction

   task automatic wait_idle();
      int waited;
      waited = 0;
      while (!stalled && !all_done() && waited < wait_limit)
      begin
         @(negedge s2mm_clk);
         waited++;
      end
      if (!stalled && !all_done())
      begin
         if (exp_beats.size() != 0)
            $display("timeout: %0d good beats never arrived", exp_beats.size());
         if (exp_status.size() != 0)
            $display("timeout: %0d status words never arrived", exp_status.size());
         if (dbg_busy || !dut.info_empty)
            $display("timeout: a frame was never finished by the dut");
         errors++;
         stalled = 1'b1;
      end
   endtask

   // readers stay paused until back-pressure has held a waiting frame back
   task automatic hold_until_afull();
      int waited;
      waited = 0;
      @(negedge s2mm_clk);
      while (!(dut.good_afull || dut.ctrl_afull) && waited < wait_limit)
      begin
         @(negedge s2mm_clk);
         waited++;
      end
      if (!(dut.good_afull || dut.ctrl_afull))
      begin
         $display("timeout: output fifos never reached the almost-full level");
         errors++;
      end
      else
      begin
         // frame in flight still completes
         waited = 0;
         while (dbg_busy && waited < wait_limit)
         begin
            @(negedge s2mm_clk);
            waited++;
         end
         if (dbg_busy)
         begin
            $display("timeout: frame in flight never finished while the outputs were held");
            errors++;
         end
         else
         begin
            // next info word has to wait for room
            waited = 0;
            while (!dbg_busy && dut.info_empty && waited < wait_limit)
            begin
               @(negedge s2mm_clk);
               waited++;
            end
            if (!dbg_busy && dut.info_empty)
            begin
               $display("timeout: no further frame arrived while the outputs were held");
               errors++;
            end
            else
            begin
               repeat (hold_window) @(negedge s2mm_clk);
               checks++;
               if (dbg_busy)
               begin
                  errors++;
                  $display("CHECK FAILED at %0t: frame admitted with an output fifo almost full",
                     $time);
               end
            end
         end
      end
      @(posedge s2mm_clk);
      drain_en = 1'b1;
   endtask

   task automatic check_beat(input data_beat_t got);
      data_beat_t want;
      checks++;
      if (exp_beats.size() == 0)
      begin
         errors++;
         $display("CHECK FAILED at %0t: good beat %h with none expected", $time, got);
      end
      else
      begin
         want = exp_beats.pop_front();
         if (got !== want)
         begin
            errors++;
            $display("CHECK FAILED at %0t: good beat %h, expected %h", $time, got, want);
         end
      end
   endtask

   task automatic check_status(input status_word_t got);
      status_word_t want;
      checks++;
      if (exp_status.size() == 0)
      begin
         errors++;
         $display("CHECK FAILED at %0t: status word %h with none expected", $time, got);
      end
      else
      begin
         want = exp_status.pop_front();
         if (got !== want)
         begin
            errors++;
            $display("CHECK FAILED at %0t: status word %h, expected %h", $time, got, want);
         end
      end
   endtask

   // drain both output fifos and compare what comes out
   always @(negedge s2mm_clk)
   begin
      if (!drain_en)
      begin
         good_rden = 1'b0;
         ctrl_rden = 1'b0;
      end
      else
      begin
         good_rden = !good_empty;
         ctrl_rden = !ctrl_empty;
         if (!good_empty)
            check_beat(good_rdata);
         if (!ctrl_empty)
            check_status(ctrl_rdata);
      end
   end

   task automatic end_test(input string name);
      tests++;
      $display("test %s done, %0d errors", name, errors - test_err_base);
      test_err_base = errors;
   endtask

   initial
   begin
      void'($urandom(6));
      s2mm_resetn = 1'b0;
      in_beat = '0;
      in_beat_wren = 1'b0;
      in_info = '0;
      in_info_wren = 1'b0;
      good_rden = 1'b0;
      ctrl_rden = 1'b0;
      drain_en = 1'b0;
      stalled = 1'b0;
      errors = 0;
      checks = 0;
      tests = 0;
      test_err_base = 0;
      repeat (2) @(posedge s2mm_clk);
      @(negedge s2mm_clk);
      s2mm_resetn = 1'b1;
      @(negedge s2mm_clk);

      checks += 3;
      if (good_empty !== 1'b1)
      begin
         errors++;
         $display("CHECK FAILED at %0t: good_empty low after reset", $time);
      end
      if (ctrl_empty !== 1'b1)
      begin
         errors++;
         $display("CHECK FAILED at %0t: ctrl_empty low after reset", $time);
      end
      if (dbg_busy !== 1'b0)
      begin
         errors++;
         $display("CHECK FAILED at %0t: dbg_busy high after reset", $time);
      end
      end_test("reset");
      @(posedge s2mm_clk);
      drain_en = 1'b1;
      @(negedge s2mm_clk);

      repeat (8) send_frame(0, 0);
      wait_idle();
      end_test("passed frames");

      // bad frames interleaved with good ones and back to back
      send_frame(0, 0);
      send_frame(1, 0);
      send_frame(1, 1);
      send_frame(0, 1);
      send_frame(1, 0);
      send_frame(0, 0);
      wait_idle();
      end_test("dropped frames");

      repeat (10) send_frame(0, 1);
      wait_idle();
      end_test("status words");

      repeat (6) send_frame(0, 2);
      repeat (6) send_frame(2, 1);
      wait_idle();
      end_test("byte count");

      @(posedge s2mm_clk);
      drain_en = 1'b0;
      @(negedge s2mm_clk);
      fork
         repeat (20) send_frame(0, 1);
         hold_until_afull();
      join
      wait_idle();
      end_test("back-pressure");

      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: verif/s2mm_rx_properties.sv
// ############################################################
// assertions on the fifo strobes and control word grouping
// attached to the receive tail top level by bind
// ############################################################
`timescale 1ns/1ps
`default_nettype none
`include "s2mm_settings.svh"

module s2mm_rx_properties
   import s2mm_pkg::*;
(
   input wire logic         s2mm_clk,
   input wire logic         s2mm_resetn,
   input wire logic         data_rden,
   input wire logic         data_empty,
   input wire logic         info_rden,
   input wire logic         info_empty,
   input wire logic         good_rden,
   input wire logic         good_empty,
   input wire logic         ctrl_rden,
   input wire logic         ctrl_empty,
   input wire logic         in_beat_wren,
   input wire logic         data_full,
   input wire logic         in_info_wren,
   input wire logic         info_full,
   input wire logic         good_wren,
   input wire logic         good_full,
   input wire logic         ctrl_wren,
   input wire logic         ctrl_full,
   input wire status_word_t ctrl_wdata
);
   // control writes seen since the last word of the previous frame
   logic [3:0] ctrl_since_last;

   always_ff @(posedge s2mm_clk or negedge s2mm_resetn)
   begin
      if (!s2mm_resetn)
      begin
         ctrl_since_last <= '0;
      end
      else if (ctrl_wren)
      begin
         ctrl_since_last <= ctrl_wdata.last ? 4'd0 : ctrl_since_last + 4'd1;
      end
   end

   // any of the four fifos
   no_read_empty: assert property (@(posedge s2mm_clk) disable iff (!s2mm_resetn)
      !((data_rden && data_empty) || (info_rden && info_empty) ||
        (good_rden && good_empty) || (ctrl_rden && ctrl_empty)))
      else $error("fifo read while empty");

   no_write_full: assert property (@(posedge s2mm_clk) disable iff (!s2mm_resetn)
      !((in_beat_wren && data_full) || (in_info_wren && info_full) ||
        (good_wren && good_full) || (ctrl_wren && ctrl_full)))
      else $error("fifo write while full");

   // last word closes a group of six
   last_is_sixth: assert property (@(posedge s2mm_clk) disable iff (!s2mm_resetn)
      (ctrl_wren && ctrl_wdata.last) |-> (ctrl_since_last == `S2MM_STATUS_WORDS - 1))
      else $error("control word with last is not the sixth of its frame");

endmodule

bind s2mm_rx_top s2mm_rx_properties u_props (
   .s2mm_clk, .s2mm_resetn, .data_rden, .data_empty, .info_rden, .info_empty,
   .good_rden, .good_empty, .ctrl_rden, .ctrl_empty, .in_beat_wren, .data_full,
   .in_info_wren, .info_full, .good_wren, .good_full, .ctrl_wren, .ctrl_full,
   .ctrl_wdata
);

`default_nettype wire

// File: logic/s2mm_rx_top.sv
// ############################################################
// receive tail in front of the dma stream-to-memory channel
// input fifos, admit, mover and status stages, output fifos
// ############################################################
`timescale 1ns/1ps
`default_nettype none
`include "s2mm_settings.svh"

module s2mm_rx_top
   import s2mm_pkg::*;
(
   input  wire logic       s2mm_clk,
   input  wire logic       s2mm_resetn,
   input  wire data_beat_t in_beat,
   input  wire logic       in_beat_wren,
   input  wire info_word_t in_info,
   input  wire logic       in_info_wren,
   input  wire logic       good_rden,
   output data_beat_t      good_rdata,
   output logic            good_empty,
   input  wire logic       ctrl_rden,
   output status_word_t    ctrl_rdata,
   output logic            ctrl_empty,
   output logic            dbg_busy
);
   // fifo side
   data_beat_t   data_beat;
   logic         data_rden, data_empty, data_full;
   info_word_t   info_word;
   logic         info_rden, info_empty, info_full;
   data_beat_t   good_wdata;
   logic         good_wren, good_afull, good_full;
   status_word_t ctrl_wdata;
   logic         ctrl_wren, ctrl_afull, ctrl_full;
   // stage side
   frame_cmd_t   cmd;
   logic         start, pass_end, drop_end, csum_ok, status_done;
   logic [15:0]  byte_count;

   sync_fifo #(.width($bits(data_beat_t)), .depth(`S2MM_DATA_FIFO_DEPTH), .afull_free(1))
   u_data_fifo (.s2mm_clk, .s2mm_resetn, .wren(in_beat_wren), .wdata(in_beat),
      .rden(data_rden), .rdata(data_beat), .empty(data_empty), .full(data_full), .afull());

   sync_fifo #(.width($bits(info_word_t)), .depth(`S2MM_INFO_FIFO_DEPTH), .afull_free(1))
   u_info_fifo (.s2mm_clk, .s2mm_resetn, .wren(in_info_wren), .wdata(in_info),
      .rden(info_rden), .rdata(info_word), .empty(info_empty), .full(info_full), .afull());

   // headroom of one longest frame
   sync_fifo #(.width($bits(data_beat_t)), .depth(`S2MM_GOOD_FIFO_DEPTH),
      .afull_free(`S2MM_FRAME_MAX_BEATS))
   u_good_fifo (.s2mm_clk, .s2mm_resetn, .wren(good_wren), .wdata(good_wdata),
      .rden(good_rden), .rdata(good_rdata), .empty(good_empty), .full(good_full),
      .afull(good_afull));

   // headroom of one frame's status words
   sync_fifo #(.width($bits(status_word_t)), .depth(`S2MM_CTRL_FIFO_DEPTH),
      .afull_free(`S2MM_STATUS_WORDS))
   u_ctrl_fifo (.s2mm_clk, .s2mm_resetn, .wren(ctrl_wren), .wdata(ctrl_wdata),
      .rden(ctrl_rden), .rdata(ctrl_rdata), .empty(ctrl_empty), .full(ctrl_full),
      .afull(ctrl_afull));

   rx_frame_admit u_admit (.s2mm_clk, .s2mm_resetn, .info(info_word), .info_empty,
      .good_afull, .ctrl_afull, .drop_end, .status_done, .start, .cmd, .dbg_busy);

   rx_beat_mover u_mover (.s2mm_clk, .s2mm_resetn, .start, .cmd, .beat(data_beat),
      .data_rden, .info_rden, .good_wren, .good_wdata, .pass_end, .drop_end,
      .byte_count, .csum_ok);

   rx_status_writer u_status (.s2mm_clk, .s2mm_resetn, .pass_end, .byte_count, .csum_ok,
      .ctrl_wren, .ctrl_wdata, .status_done);

endmodule

`default_nettype wire

// File: logic/rx_status_writer.sv
// ############################################################
// result stage, writes the control words of a passed frame
// six words on consecutive cycles, then a done pulse
// ############################################################
`timescale 1ns/1ps
`default_nettype none
`include "s2mm_settings.svh"

module rx_status_writer
   import s2mm_pkg::*;
(
   input  wire logic        s2mm_clk,
   input  wire logic        s2mm_resetn,
   input  wire logic        pass_end,
   input  wire logic [15:0] byte_count,
   input  wire logic        csum_ok,
   output logic             ctrl_wren,
   output status_word_t     ctrl_wdata,
   output logic             status_done
);
   localparam int wcw = $clog2(`S2MM_STATUS_WORDS);
   // word slots in the control stream
   localparam logic [wcw-1:0] flags_word = '0;
   localparam logic [wcw-1:0] app_word   = wcw'(3);
   localparam logic [wcw-1:0] last_word  = wcw'(`S2MM_STATUS_WORDS - 1);

   logic           active;
   logic [wcw-1:0] word_cnt;
   logic [15:0]    len_q;
   logic           csum_q;

   always_ff @(posedge s2mm_clk or negedge s2mm_resetn)
   begin
      if (!s2mm_resetn)
      begin
         active      <= 1'b0;
         word_cnt    <= '0;
         status_done <= 1'b0;
      end
      else
      begin
         status_done <= active & (word_cnt == last_word);
         if (pass_end)
         begin
            active <= 1'b1;
         end
         else if (active)
         begin
            if (word_cnt == last_word)
            begin
               active   <= 1'b0;
               word_cnt <= '0;
            end
            else
            begin
               word_cnt <= word_cnt + 1'b1;
            end
         end
      end
   end

   // frame results captured once per frame
   always_ff @(posedge s2mm_clk)
   begin
      if (pass_end)
      begin
         len_q  <= byte_count;
         csum_q <= csum_ok;
      end
   end

   assign ctrl_wren = active;

   // mcast address and tag words stay zero
   always_comb
   begin
      ctrl_wdata      = '0;
      ctrl_wdata.strb = 4'b1111;
      case (word_cnt)
         flags_word:
         begin
            ctrl_wdata.payload = 32'h5000_0000;
         end
         app_word:
         begin
            ctrl_wdata.payload.app_view.csum_fail = ~csum_q;
            ctrl_wdata.payload.app_view.csum_ok   = csum_q;
         end
         last_word:
         begin
            ctrl_wdata.last                        = 1'b1;
            ctrl_wdata.payload.len_view.byte_count = len_q;
         end
         default:
         begin
            ctrl_wdata.payload = '0;
         end
      endcase
   end

endmodule

`default_nettype wire

// File: logic/rx_beat_mover.sv
// ############################################################
// execute stage, moves one frame's beats out of the data fifo
// passed frames go to the good fifo with a byte count
// ############################################################
`timescale 1ns/1ps
`default_nettype none

module rx_beat_mover
   import s2mm_pkg::*;
(
   input  wire logic       s2mm_clk,
   input  wire logic       s2mm_resetn,
   input  wire logic       start,
   input  wire frame_cmd_t cmd,
   input  wire data_beat_t beat,
   output logic            data_rden,
   output logic            info_rden,
   output logic            good_wren,
   output data_beat_t      good_wdata,
   output logic            pass_end,
   output logic            drop_end,
   output logic [15:0]     byte_count,
   output logic            csum_ok
);
   typedef enum logic [1:0] {mv_idle, mv_pass, mv_drop} move_state_t;

   move_state_t state;
   logic        pass_last;
   logic        drop_last;
   logic [3:0]  beat_bytes;
   logic [15:0] frame_len;
   logic        csum_q;

   // only contiguous keep from bit 0 counts, anything else is 0
   function automatic logic [3:0] keep_bytes(input logic [7:0] keep);
      logic [3:0] n;
      case (keep)
         8'h01:   n = 4'd1;
         8'h03:   n = 4'd2;
         8'h07:   n = 4'd3;
         8'h0f:   n = 4'd4;
         8'h1f:   n = 4'd5;
         8'h3f:   n = 4'd6;
         8'h7f:   n = 4'd7;
         8'hff:   n = 4'd8;
         default: n = 4'd0;
      endcase
      return n;
   endfunction

   // one read per cycle until last, beats are already in the fifo
   assign data_rden = (state != mv_idle);

   always_ff @(posedge s2mm_clk or negedge s2mm_resetn)
   begin
      if (!s2mm_resetn)
      begin
         state     <= mv_idle;
         good_wren <= 1'b0;
         pass_last <= 1'b0;
         drop_last <= 1'b0;
         pass_end  <= 1'b0;
         drop_end  <= 1'b0;
      end
      else
      begin
         good_wren <= (state == mv_pass);
         pass_last <= (state == mv_pass) & beat.last;
         drop_last <= (state == mv_drop) & beat.last;
         // count has settled by now
         pass_end  <= pass_last;
         drop_end  <= drop_last;
         case (state)
            mv_idle:
            begin
               if (start)
               begin
                  state <= cmd.drop ? mv_drop : mv_pass;
               end
            end
            mv_pass, mv_drop:
            begin
               if (beat.last)
               begin
                  state <= mv_idle;
               end
            end
            default: state <= mv_idle;
         endcase
      end
   end

   // frame's info word popped one cycle after its last beat
   assign info_rden = pass_last | drop_last;

   always_ff @(posedge s2mm_clk)
   begin
      good_wdata <= beat;
      beat_bytes <= keep_bytes(beat.keep);
      if (start)
      begin
         frame_len <= '0;
         csum_q    <= cmd.csum_ok;
      end
      else if (good_wren)
      begin
         // bytes of the beat written this cycle
         frame_len <= frame_len + {12'h000, beat_bytes};
      end
   end

   assign byte_count = frame_len;
   assign csum_ok    = csum_q;

endmodule

`default_nettype wire

// File: logic/rx_frame_admit.sv
// ############################################################
// decode stage, admits one frame at a time from the info fifo
// start pulse carries the latched frame command
// ############################################################
`timescale 1ns/1ps
`default_nettype none

module rx_frame_admit
   import s2mm_pkg::*;
(
   input  wire logic       s2mm_clk,
   input  wire logic       s2mm_resetn,
   input  wire info_word_t info,
   input  wire logic       info_empty,
   input  wire logic       good_afull,
   input  wire logic       ctrl_afull,
   input  wire logic       drop_end,
   input  wire logic       status_done,
   output logic            start,
   output frame_cmd_t      cmd,
   output logic            dbg_busy
);
   typedef enum logic {idle, busy} admit_state_t;

   admit_state_t state;
   logic         admit;

   // both output fifos need room for a whole frame
   assign admit = (state == idle) & ~info_empty & ~good_afull & ~ctrl_afull;

   always_ff @(posedge s2mm_clk or negedge s2mm_resetn)
   begin
      if (!s2mm_resetn)
      begin
         state <= idle;
         start <= 1'b0;
      end
      else
      begin
         start <= admit;
         case (state)
            idle:
            begin
               if (admit)
               begin
                  state <= busy;
               end
            end
            busy:
            begin
               // a dropped frame ends at the mover, a passed one after its status words
               if (drop_end | status_done)
               begin
                  state <= idle;
               end
            end
         endcase
      end
   end

   // held for the whole frame, info word is popped mid-frame
   always_ff @(posedge s2mm_clk)
   begin
      if (admit)
      begin
         cmd.drop    <= info.bad;
         cmd.csum_ok <= info.csum_ok;
      end
   end

   assign dbg_busy = (state == busy);

endmodule

`default_nettype wire

// File: logic/sync_fifo.sv
// ############################################################
// synchronous fifo with first-word-fall-through read data
// afull rises when fewer than afull_free entries are free
// ############################################################
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
   parameter int width      = 8,
   parameter int depth      = 16,
   parameter int afull_free = 1
) (
   input  wire logic             s2mm_clk,
   input  wire logic             s2mm_resetn,
   input  wire logic             wren,
   input  wire logic [width-1:0] wdata,
   input  wire logic             rden,
   output logic      [width-1:0] rdata,
   output logic                  empty,
   output logic                  full,
   output logic                  afull
);
   localparam int aw = (depth > 1) ? $clog2(depth) : 1;
   localparam int cw = $clog2(depth + 1);
   localparam logic [aw-1:0] last_idx    = aw'(depth - 1);
   localparam logic [cw-1:0] full_level  = cw'(depth);
   localparam logic [cw-1:0] afull_level = cw'(depth - afull_free);

   logic [width-1:0] mem [depth];
   logic [aw-1:0]    wr_ptr;
   logic [aw-1:0]    rd_ptr;
   logic [cw-1:0]    count;
   logic             push;
   logic             pop;

   // strobes ignored at the limits
   assign push = wren & ~full;
   assign pop  = rden & ~empty;

   always_ff @(posedge s2mm_clk)
   begin
      if (push)
      begin
         mem[wr_ptr] <= wdata;
      end
   end

   always_ff @(posedge s2mm_clk or negedge s2mm_resetn)
   begin
      if (!s2mm_resetn)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         // pointers wrap at depth, not only at powers of two
         if (push)
         begin
            wr_ptr <= (wr_ptr == last_idx) ? '0 : wr_ptr + 1'b1;
         end
         if (pop)
         begin
            rd_ptr <= (rd_ptr == last_idx) ? '0 : rd_ptr + 1'b1;
         end
         count <= count + cw'(push) - cw'(pop);
      end
   end

   // head entry always visible
   assign rdata = mem[rd_ptr];
   assign empty = (count == '0);
   assign full  = (count == full_level);
   assign afull = (count > afull_level);

endmodule

`default_nettype wire

// File: logic/s2mm_pkg.sv
// ############################################################
// shared types of the s2mm receive tail
// imported by the stages and the top level
// ############################################################
`default_nettype none

package s2mm_pkg;

   // one stream beat, as held in the data and good fifos
   typedef struct packed {
      logic        last;
      logic [7:0]  keep;
      logic [63:0] data;
   } data_beat_t;

   // per-frame status from the mac side
   typedef struct packed {
      logic       bad;
      logic [5:0] rsvd;
      logic       csum_ok;
   } info_word_t;

   // app word layout, checksum flags at bits 7 and 6
   typedef struct packed {
      logic [23:0] rsvd_hi;
      logic        csum_fail;
      logic        csum_ok;
      logic [5:0]  rsvd_lo;
   } app_word_t;

   // last word layout, byte count in the low half
   typedef struct packed {
      logic [15:0] rsvd;
      logic [15:0] byte_count;
   } len_word_t;

   typedef union packed {
      app_word_t app_view;
      len_word_t len_view;
   } status_payload_u;

   // one control fifo entry
   typedef struct packed {
      logic            last;
      logic [3:0]      strb;
      status_payload_u payload;
   } status_word_t;

   // admitted frame, valid with the start pulse
   typedef struct packed {
      logic drop;
      logic csum_ok;
   } frame_cmd_t;

endpackage

`default_nettype wire

// File: include/s2mm_settings.svh
// ############################################################
// sizes and limits for the s2mm receive tail
// include wherever fifo depths or frame limits are needed
// ############################################################
`ifndef S2MM_SETTINGS_SVH
`define S2MM_SETTINGS_SVH

// fifo entry counts
`define S2MM_DATA_FIFO_DEPTH 64
`define S2MM_INFO_FIFO_DEPTH 16
`define S2MM_GOOD_FIFO_DEPTH 64
`define S2MM_CTRL_FIFO_DEPTH 32

// longest frame in beats, also the good fifo headroom
`define S2MM_FRAME_MAX_BEATS 16
// status words per passed frame, also the ctrl fifo headroom
`define S2MM_STATUS_WORDS 6

`endif
